// ==== include/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Datapath and immediate width
`define XLEN 32

`define NUM_WARPS 4
`define NW_WIDTH 2

// Thread mask width
`define NUM_THREADS 4

`define UUID_WIDTH 8

`define NR_BITS 5
`define CSR_ADDR_BITS 12

`endif

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

    // RV32 base opcodes plus the custom-0 warp-control space
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        FENCE  = 7'b0001111,
        SYSTEM = 7'b1110011,
        EXT1   = 7'b0001011
    } opcode_e;

    typedef struct packed {
        logic [6:0] func7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_view_t;

    // One 32-bit word seen as register fields or with a 12-bit immediate on top
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_u;

endpackage

// ==== verilog/uop_pkg.sv ====
`include "decode_params.svh"

package uop_pkg;

    typedef logic [3:0] op_type_t;
    typedef logic [2:0] op_mod_t;

    typedef enum logic [1:0] {
        EX_NONE = 2'd0, // illegal instruction
        EX_ALU  = 2'd1,
        EX_LSU  = 2'd2,
        EX_SFU  = 2'd3
    } ex_type_e;

    typedef enum logic [3:0] {
        CLS_NONE, CLS_ALU_R, CLS_ALU_I, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
        CLS_BRANCH, CLS_LOAD, CLS_STORE, CLS_FENCE, CLS_SYS, CLS_CSR, CLS_WCTL
    } op_class_e;

    typedef enum logic [3:0] {
        IMM_NONE, IMM_I, IMM_I_SH, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CSR, IMM_CONST4
    } imm_fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_EQ   = 4'b0000, BR_NE   = 4'b0010, BR_LTU  = 4'b0100, BR_GEU = 4'b0110,
        BR_LT   = 4'b0101, BR_GE   = 4'b0111, BR_JAL  = 4'b1000, BR_JALR = 4'b1001,
        BR_ECALL = 4'b1010, BR_EBREAK = 4'b1011, BR_URET = 4'b1100,
        BR_SRET = 4'b1101, BR_MRET = 4'b1110
    } br_op_e;

    typedef enum logic [3:0] {
        M_MUL, M_MULH, M_MULHSU, M_MULHU, M_DIV, M_DIVU, M_REM, M_REMU
    } m_op_e;

    typedef enum logic [3:0] {
        SFU_TMC, SFU_WSPAWN, SFU_SPLIT, SFU_JOIN, SFU_BAR, SFU_PRED,
        SFU_CSRRW, SFU_CSRRS, SFU_CSRRC
    } sfu_op_e;

    // Loads are {0, func3}, stores {1, func3}
    localparam op_type_t LSU_FENCE = 4'hf;

    localparam op_mod_t MOD_BR = 3'b001;
    localparam op_mod_t MOD_M  = 3'b010;

    typedef struct packed {
        logic [`UUID_WIDTH-1:0]  uuid;
        logic [`NW_WIDTH-1:0]    wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        logic [31:0]             instr;
    } fetch_req_t;

    typedef struct packed {
        logic [`UUID_WIDTH-1:0]  uuid;
        logic [`NW_WIDTH-1:0]    wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`XLEN-1:0]        pc;
        ex_type_e                ex_type;
        op_type_t                op_type;
        op_mod_t                 op_mod;
        logic                    use_pc;
        logic [`XLEN-1:0]        imm;
        logic                    use_imm;
        logic                    wb;
        logic [`NR_BITS-1:0]     rd;
        logic [`NR_BITS-1:0]     rs1;
        logic [`NR_BITS-1:0]     rs2;
        logic [`NR_BITS-1:0]     rs3;
    } uop_t;

    typedef struct packed {
        logic [`NW_WIDTH-1:0] wid;
        logic                 is_wstall;
    } sched_note_t;

endpackage

// ==== verilog/opcode_decoder.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module opcode_decoder
    import isa_pkg::*;
    import uop_pkg::*;
(
    input  instr_u              instr,
    output ex_type_e            ex_type,
    output op_class_e           op_class,
    output imm_fmt_e            imm_fmt,
    output logic                use_pc,
    output logic                use_imm,
    output logic                wb,
    output logic [`NR_BITS-1:0] rd,
    output logic [`NR_BITS-1:0] rs1,
    output logic [`NR_BITS-1:0] rs2,
    output logic [`NR_BITS-1:0] rs3,
    output logic                is_wstall
);

    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;
    logic [2:0] func3;
    logic [6:0] func7;

    assign func3 = instr.r_view.func3;
    assign func7 = instr.r_view.func7;

    always_comb begin
        ex_type   = EX_NONE;
        op_class  = CLS_NONE;
        imm_fmt   = IMM_NONE;
        use_pc    = 1'b0;
        use_imm   = 1'b0;
        use_rd    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_wstall = 1'b0;

        case (instr.r_view.opcode)
            OP: begin
                ex_type  = EX_ALU;
                op_class = CLS_ALU_R; // M ops resolved by func7[0] downstream
                use_rd   = 1'b1;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            OP_IMM: begin
                ex_type  = EX_ALU;
                op_class = CLS_ALU_I;
                imm_fmt  = (func3[1:0] == 2'b01) ? IMM_I_SH : IMM_I; // slli/srli/srai
                use_imm  = 1'b1;
                use_rd   = 1'b1;
                use_rs1  = 1'b1;
            end
            LUI, AUIPC: begin
                ex_type  = EX_ALU;
                op_class = (instr.r_view.opcode == LUI) ? CLS_LUI : CLS_AUIPC;
                imm_fmt  = IMM_U;
                use_imm  = 1'b1;
                use_pc   = (instr.r_view.opcode == AUIPC);
                use_rd   = 1'b1;
            end
            JAL: begin
                ex_type   = EX_ALU;
                op_class  = CLS_JAL;
                imm_fmt   = IMM_J;
                use_imm   = 1'b1;
                use_pc    = 1'b1;
                use_rd    = 1'b1;
                is_wstall = 1'b1;
            end
            JALR: begin
                ex_type   = EX_ALU;
                op_class  = CLS_JALR;
                imm_fmt   = IMM_I;
                use_imm   = 1'b1;
                use_rd    = 1'b1;
                use_rs1   = 1'b1;
                is_wstall = 1'b1;
            end
            BRANCH: begin
                ex_type   = EX_ALU;
                op_class  = CLS_BRANCH;
                imm_fmt   = IMM_B;
                use_imm   = 1'b1;
                use_pc    = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                is_wstall = 1'b1;
            end
            LOAD: begin
                ex_type  = EX_LSU;
                op_class = CLS_LOAD;
                imm_fmt  = IMM_I;
                use_imm  = 1'b1;
                use_rd   = 1'b1;
                use_rs1  = 1'b1;
            end
            STORE: begin
                ex_type  = EX_LSU;
                op_class = CLS_STORE;
                imm_fmt  = IMM_S;
                use_imm  = 1'b1;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            FENCE: begin
                ex_type  = EX_LSU;
                op_class = CLS_FENCE;
            end
            SYSTEM: begin
                use_rd    = 1'b1;
                is_wstall = 1'b1;
                if (func3[1:0] != 2'b00) begin
                    ex_type  = EX_SFU;
                    op_class = CLS_CSR;
                    imm_fmt  = IMM_CSR;
                    use_imm  = func3[2];
                    use_rs1  = ~func3[2]; // csrr*i take zimm instead of rs1
                end else begin
                    // ecall/ebreak/xret resolved as a branch-type ALU op
                    ex_type  = EX_ALU;
                    op_class = CLS_SYS;
                    imm_fmt  = IMM_CONST4;
                    use_imm  = 1'b1;
                    use_pc   = 1'b1;
                end
            end
            EXT1: begin
                if (func7 == 7'h00 && func3 <= 3'h5) begin
                    ex_type   = EX_SFU;
                    op_class  = CLS_WCTL;
                    is_wstall = 1'b1;
                    use_rs1   = 1'b1;
                    use_rs2   = (func3 == 3'h1) || (func3 == 3'h4) || (func3 == 3'h5);
                    use_rd    = (func3 == 3'h2); // split returns the old mask
                end
            end
            default: ;
        endcase
    end

    assign rd  = use_rd ? instr.r_view.rd : '0;
    assign rs1 = use_rs1 ? instr.r_view.rs1 : '0;
    assign rs2 = use_rs2 ? instr.r_view.rs2 : '0;
    assign rs3 = '0; // no three-source ops in this subset
    assign wb  = use_rd && (instr.r_view.rd != '0);

endmodule

// ==== verilog/func_decoder.sv ====
`timescale 1ns/1ps

module func_decoder
    import isa_pkg::*;
    import uop_pkg::*;
(
    input  instr_u    instr,
    input  op_class_e op_class,
    output op_type_t  op_type,
    output op_mod_t   op_mod
);

    logic [2:0] func3;
    logic [6:0] func7;
    alu_op_e    alu_op;
    br_op_e     br_op;
    br_op_e     sys_op;
    m_op_e      m_op;
    sfu_op_e    csr_op;
    sfu_op_e    wctl_op;

    assign func3 = instr.i_view.func3;
    assign func7 = instr.r_view.func7;

    always_comb begin
        case (func3)
            3'h0: alu_op = (op_class == CLS_ALU_R && func7[5]) ? ALU_SUB : ALU_ADD;
            3'h1: alu_op = ALU_SLL;
            3'h2: alu_op = ALU_SLT;
            3'h3: alu_op = ALU_SLTU;
            3'h4: alu_op = ALU_XOR;
            3'h5: alu_op = func7[5] ? ALU_SRA : ALU_SRL; // imm[10] for srai
            3'h6: alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (func3)
            3'h1: br_op = BR_NE;
            3'h4: br_op = BR_LT;
            3'h5: br_op = BR_GE;
            3'h6: br_op = BR_LTU;
            3'h7: br_op = BR_GEU;
            default: br_op = BR_EQ;
        endcase
    end

    always_comb begin
        case (instr.i_view.imm12)
            12'h001: sys_op = BR_EBREAK;
            12'h002: sys_op = BR_URET;
            12'h102: sys_op = BR_SRET;
            12'h302: sys_op = BR_MRET;
            default: sys_op = BR_ECALL;
        endcase
    end

    // func3 order matches mul..remu directly
    assign m_op = m_op_e'({1'b0, func3});

    always_comb begin
        case (func3[1:0])
            2'b10: csr_op = SFU_CSRRS;
            2'b11: csr_op = SFU_CSRRC;
            default: csr_op = SFU_CSRRW;
        endcase
    end

    always_comb begin
        case (func3)
            3'h1: wctl_op = SFU_WSPAWN;
            3'h2: wctl_op = SFU_SPLIT;
            3'h3: wctl_op = SFU_JOIN;
            3'h4: wctl_op = SFU_BAR;
            3'h5: wctl_op = SFU_PRED;
            default: wctl_op = SFU_TMC;
        endcase
    end

    always_comb begin
        op_type = '0;
        op_mod  = '0;
        case (op_class)
            CLS_ALU_R: begin
                if (func7[0]) begin
                    op_type = m_op;
                    op_mod  = MOD_M;
                end else begin
                    op_type = alu_op;
                end
            end
            CLS_ALU_I: op_type = alu_op;
            CLS_LUI:   op_type = ALU_LUI;
            CLS_AUIPC: op_type = ALU_AUIPC;
            CLS_JAL: begin
                op_type = BR_JAL;
                op_mod  = MOD_BR;
            end
            CLS_JALR: begin
                op_type = BR_JALR;
                op_mod  = MOD_BR;
            end
            CLS_BRANCH: begin
                op_type = br_op;
                op_mod  = MOD_BR;
            end
            CLS_SYS: begin
                op_type = sys_op;
                op_mod  = MOD_BR;
            end
            CLS_LOAD:  op_type = {1'b0, func3};
            CLS_STORE: op_type = {1'b1, func3};
            CLS_FENCE: op_type = LSU_FENCE;
            CLS_CSR:   op_type = csr_op;
            CLS_WCTL:  op_type = wctl_op;
            default: ;
        endcase
    end

endmodule

// ==== verilog/imm_gen.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module imm_gen
    import isa_pkg::*;
    import uop_pkg::*;
(
    input  instr_u           instr,
    input  imm_fmt_e         imm_fmt,
    output logic [`XLEN-1:0] imm
);

    logic [31:0] w;
    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [20:0] j_imm;

    assign w     = instr;
    assign i_imm = instr.i_view.imm12;
    assign s_imm = {instr.r_view.func7, instr.r_view.rd};
    assign b_imm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    assign j_imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};

    always_comb begin
        case (imm_fmt)
            IMM_I:    imm = {{(`XLEN-12){i_imm[11]}}, i_imm};
            IMM_I_SH: imm = {{(`XLEN-5){1'b0}}, instr.r_view.rs2}; // shamt
            IMM_S:    imm = {{(`XLEN-12){s_imm[11]}}, s_imm};
            IMM_B:    imm = {{(`XLEN-13){b_imm[12]}}, b_imm};
            IMM_U:    imm = {w[31:12], 12'h000};
            IMM_J:    imm = {{(`XLEN-21){j_imm[20]}}, j_imm};
            IMM_CSR: begin
                // zimm sits right above the CSR address
                imm = {{(`XLEN-`CSR_ADDR_BITS-5){1'b0}},
                       instr.i_view.func3[2] ? instr.i_view.rs1 : 5'd0,
                       i_imm[`CSR_ADDR_BITS-1:0]};
            end
            IMM_CONST4: imm = `XLEN'd4; // return address offset
            default:    imm = '0;
        endcase
    end

endmodule

// ==== verilog/decode_stage_reg.sv ====
`timescale 1ns/1ps

module decode_stage_reg
    import uop_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_valid,
    output logic        fetch_ready,
    input  uop_t        uop_in,
    input  logic        is_wstall,
    output logic        uop_valid,
    input  logic        uop_ready,
    output uop_t        uop,
    output logic        sched_valid,
    output sched_note_t sched_note
);

    logic full;
    logic fetch_fire;

    // Accept when empty or when the held uop leaves this cycle
    assign fetch_ready = ~full | uop_ready;
    assign fetch_fire  = fetch_valid & fetch_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (fetch_ready) begin
            full <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            uop <= uop_in;
        end
    end

    assign uop_valid = full;

    // Scheduler sees the stall hint in the accept cycle
    assign sched_valid          = fetch_fire;
    assign sched_note.wid       = uop_in.wid;
    assign sched_note.is_wstall = is_wstall;

endmodule

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit
    import isa_pkg::*;
    import uop_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_valid,
    output logic        fetch_ready,
    input  fetch_req_t  fetch_req,
    output logic        uop_valid,
    input  logic        uop_ready,
    output uop_t        uop,
    output logic        sched_valid,
    output sched_note_t sched_note
);

    instr_u    instr;
    ex_type_e  ex_type;
    op_class_e op_class;
    imm_fmt_e  imm_fmt;
    op_type_t  op_type;
    op_mod_t   op_mod;
    uop_t      dec;
    logic      is_wstall;

    assign instr = fetch_req.instr;

    opcode_decoder u_opcode_decoder (
        .instr     (instr),
        .ex_type   (ex_type),
        .op_class  (op_class),
        .imm_fmt   (imm_fmt),
        .use_pc    (dec.use_pc),
        .use_imm   (dec.use_imm),
        .wb        (dec.wb),
        .rd        (dec.rd),
        .rs1       (dec.rs1),
        .rs2       (dec.rs2),
        .rs3       (dec.rs3),
        .is_wstall (is_wstall)
    );

    func_decoder u_func_decoder (
        .instr    (instr),
        .op_class (op_class),
        .op_type  (op_type),
        .op_mod   (op_mod)
    );

    imm_gen u_imm_gen (
        .instr   (instr),
        .imm_fmt (imm_fmt),
        .imm     (dec.imm)
    );

    assign dec.uuid    = fetch_req.uuid;
    assign dec.wid     = fetch_req.wid;
    assign dec.tmask   = fetch_req.tmask;
    assign dec.pc      = fetch_req.pc;
    assign dec.ex_type = ex_type;
    assign dec.op_type = op_type;
    assign dec.op_mod  = op_mod;

    decode_stage_reg u_stage_reg (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .uop_in      (dec),
        .is_wstall   (is_wstall),
        .uop_valid   (uop_valid),
        .uop_ready   (uop_ready),
        .uop         (uop),
        .sched_valid (sched_valid),
        .sched_note  (sched_note)
    );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD     = 4.0,
    parameter int  RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0; // released on the edge after the last reset cycle
    end

endmodule

// ==== verif/decode_checker.sv ====
`timescale 1ns/1ps

module decode_checker
    import uop_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic fetch_valid,
    input logic fetch_ready,
    input logic uop_valid,
    input logic uop_ready,
    input uop_t uop,
    input logic sched_valid
);

    int fail_count = 0;

    // Stalled uop must stay put until taken
    property p_uop_hold;
        @(posedge clk) disable iff (rst)
        (uop_valid && !uop_ready) |=> (uop_valid && $stable(uop));
    endproperty

    property p_ready_when_empty;
        @(posedge clk) disable iff (rst)
        !uop_valid |-> fetch_ready;
    endproperty

    property p_empty_after_reset;
        @(posedge clk) rst |=> !uop_valid;
    endproperty

    property p_sched_needs_fetch;
        @(posedge clk) disable iff (rst)
        sched_valid |-> fetch_valid;
    endproperty

    a_uop_hold: assert property (p_uop_hold)
        else begin
            fail_count++;
            $error("uop dropped or changed while uop_ready was low");
        end
    a_ready_when_empty: assert property (p_ready_when_empty)
        else begin
            fail_count++;
            $error("fetch_ready low with an empty stage register");
        end
    a_empty_after_reset: assert property (p_empty_after_reset)
        else begin
            fail_count++;
            $error("uop_valid high in the cycle after reset");
        end
    a_sched_needs_fetch: assert property (p_sched_needs_fetch)
        else begin
            fail_count++;
            $error("sched_valid high without fetch_valid");
        end

endmodule

// ==== verif/decode_tb.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_tb
    import uop_pkg::*;
;

    localparam int    MAX_VEC   = 64;
    localparam string STIM_FILE = "verif/decode_stimulus.txt";

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_req_t  fetch_req;
    logic        uop_valid;
    logic        uop_ready;
    uop_t        uop;
    logic        sched_valid;
    sched_note_t sched_note;

    string      names [MAX_VEC];
    fetch_req_t reqs [MAX_VEC];
    uop_t       exps [MAX_VEC];
    logic       exp_wstall [MAX_VEC];
    int         test_errs [MAX_VEC];
    int         exp_q [$];  // Accepted instruction indices in issue order

    int          n_vec       = 0;
    int          err_total   = 0;
    int          n_pass      = 0;
    int          n_fail      = 0;
    int          done_count  = 0;
    int          sched_count = 0;
    int          cycle_count = 0;
    logic        load_done   = 1'b0;
    logic [15:0] lfsr_state  = 16'd8287;

    tb_clock #(.PERIOD(4.0), .RST_CYCLES(5)) u_clock (
        .clk (clk),
        .rst (rst)
    );

    decode_unit dut (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_req   (fetch_req),
        .uop_valid   (uop_valid),
        .uop_ready   (uop_ready),
        .uop         (uop),
        .sched_valid (sched_valid),
        .sched_note  (sched_note)
    );

    bind decode_unit decode_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .uop_valid   (uop_valid),
        .uop_ready   (uop_ready),
        .uop         (uop),
        .sched_valid (sched_valid)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        string       name;
        logic [31:0] f [16];
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                  f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                    if (cnt == 17) begin
                        names[n_vec]           = name;
                        reqs[n_vec].uuid       = f[0][`UUID_WIDTH-1:0];
                        reqs[n_vec].wid        = f[1][`NW_WIDTH-1:0];
                        reqs[n_vec].tmask      = f[2][`NUM_THREADS-1:0];
                        reqs[n_vec].pc         = f[3];
                        reqs[n_vec].instr      = f[4];
                        exps[n_vec].uuid       = reqs[n_vec].uuid;
                        exps[n_vec].wid        = reqs[n_vec].wid;
                        exps[n_vec].tmask      = reqs[n_vec].tmask;
                        exps[n_vec].pc         = reqs[n_vec].pc;
                        exps[n_vec].ex_type    = ex_type_e'(f[5][1:0]);
                        exps[n_vec].op_type    = f[6][3:0];
                        exps[n_vec].op_mod     = f[7][2:0];
                        exps[n_vec].use_pc     = f[8][0];
                        exps[n_vec].imm        = f[9];
                        exps[n_vec].use_imm    = f[10][0];
                        exps[n_vec].wb         = f[11][0];
                        exps[n_vec].rd         = f[12][`NR_BITS-1:0];
                        exps[n_vec].rs1        = f[13][`NR_BITS-1:0];
                        exps[n_vec].rs2        = f[14][`NR_BITS-1:0];
                        exps[n_vec].rs3        = '0;  // never used in this ISA subset
                        exp_wstall[n_vec]      = f[15][0];
                        test_errs[n_vec]       = 0;
                        n_vec++;
                    end else if (cnt > 0) begin
                        $display("malformed stimulus line: %s", line);
                        err_total++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_field(input int idx, input string field,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s %s: expected %h, actual %h", names[idx], field, exp_v, act_v);
            test_errs[idx]++;
            err_total++;
        end
    endtask

    task automatic check_sched(input int idx);
        if (!sched_valid) begin
            $display("%s: no scheduler notice during the fetch transfer", names[idx]);
            test_errs[idx]++;
            err_total++;
        end
        check_field(idx, "sched_wid", reqs[idx].wid, sched_note.wid);
        check_field(idx, "is_wstall", exp_wstall[idx], sched_note.is_wstall);
    endtask

    task automatic report_test(input int idx);
        if (test_errs[idx] == 0) begin
            n_pass++;
            $display("test %0d %s: ok", idx, names[idx]);
        end else begin
            n_fail++;
            $display("test %0d %s: failed with %0d errors", idx, names[idx], test_errs[idx]);
        end
    endtask

    // About one cycle in four with uop_ready low
    always @(posedge clk) begin : ready_gen
        logic b0;
        lfsr_state = lfsr_next(lfsr_state);
        b0         = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        uop_ready <= !(b0 && lfsr_state[0]);
    end

    always @(negedge clk) begin : sched_monitor
        if (!rst) begin
            if (sched_valid) begin
                sched_count++;
            end
            if (sched_valid !== (fetch_valid && fetch_ready)) begin
                $display("sched_valid does not follow the fetch handshake at cycle %0d",
                         cycle_count);
                err_total++;
            end
        end
    end

    always @(negedge clk) begin : uop_monitor
        int idx;
        if (!rst && uop_valid && uop_ready) begin
            if (exp_q.size() == 0) begin
                $display("uop with uuid %h taken with no instruction outstanding", uop.uuid);
                err_total++;
            end else begin
                idx = exp_q.pop_front();
                check_field(idx, "uuid", exps[idx].uuid, uop.uuid);
                check_field(idx, "wid", exps[idx].wid, uop.wid);
                check_field(idx, "tmask", exps[idx].tmask, uop.tmask);
                check_field(idx, "pc", exps[idx].pc, uop.pc);
                check_field(idx, "ex_type", exps[idx].ex_type, uop.ex_type);
                check_field(idx, "op_type", exps[idx].op_type, uop.op_type);
                check_field(idx, "op_mod", exps[idx].op_mod, uop.op_mod);
                check_field(idx, "use_pc", exps[idx].use_pc, uop.use_pc);
                check_field(idx, "imm", exps[idx].imm, uop.imm);
                check_field(idx, "use_imm", exps[idx].use_imm, uop.use_imm);
                check_field(idx, "wb", exps[idx].wb, uop.wb);
                check_field(idx, "rd", exps[idx].rd, uop.rd);
                check_field(idx, "rs1", exps[idx].rs1, uop.rs1);
                check_field(idx, "rs2", exps[idx].rs2, uop.rs2);
                check_field(idx, "rs3", exps[idx].rs3, uop.rs3);
                report_test(idx);
                done_count++;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (load_done);
        limit = 8 * n_vec + 50;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d of %0d tests finished",
                 cycle_count, done_count, n_vec);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        int i;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        uop_ready   = 1'b0;
        load_vectors();
        load_done = 1'b1;
        if (n_vec == 0) begin
            $display("no test vectors loaded from %s", STIM_FILE);
            err_total++;
        end else begin
            do @(posedge clk); while (rst);
            for (i = 0; i < n_vec; i++) begin
                fetch_valid <= 1'b1;
                fetch_req   <= reqs[i];
                @(negedge clk);
                while (!fetch_ready) @(negedge clk);
                check_sched(i); // transfer happens on the coming edge
                exp_q.push_back(i);
                @(posedge clk);
            end
            fetch_valid <= 1'b0;
            wait (done_count == n_vec);
            repeat (4) @(posedge clk);
            if (sched_count != n_vec) begin
                $display("saw %0d scheduler notices for %0d instructions", sched_count, n_vec);
                err_total++;
            end
            if (uop_valid) begin
                $display("stage register still holds a uop after the last test");
                err_total++;
            end
        end
        if (dut.u_checker.fail_count != 0) begin
            $display("%0d handshake assertion failures", dut.u_checker.fail_count);
            err_total += dut.u_checker.fail_count;
        end
        $display("tests: %0d, passed: %0d, failed: %0d, errors: %0d",
                 n_vec, n_pass, n_fail, err_total);
        if (err_total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verif/decode_stimulus.txt ====
# name uuid wid tmask pc instr | expected: ex_type op_type op_mod use_pc imm use_imm wb rd rs1 rs2
# is_wstall; all values hex, rs3 is always 0
add        01 0 f 00001000 003100b3 1 0 0 0 00000000 0 1 01 02 03 0
sub        02 1 f 00001004 407302b3 1 1 0 0 00000000 0 1 05 06 07 0
sll        03 2 3 00001008 00a49433 1 2 0 0 00000000 0 1 08 09 0a 0
sltu       04 3 f 0000100c 003130b3 1 4 0 0 00000000 0 1 01 02 03 0
sra        05 0 1 00001010 403150b3 1 7 0 0 00000000 0 1 01 02 03 0
add_x0     06 1 f 00001014 00208033 1 0 0 0 00000000 0 0 00 01 02 0
mul        07 2 f 00001018 025201b3 1 0 2 0 00000000 0 1 03 04 05 0
divu       08 3 8 0000101c 025251b3 1 5 2 0 00000000 0 1 03 04 05 0
remu       09 0 f 00001020 025271b3 1 7 2 0 00000000 0 1 03 04 05 0
addi_neg   0a 1 f 00001024 fff10093 1 0 0 0 ffffffff 1 1 01 02 00 0
xori       0b 2 f 00001028 7ff2c213 1 5 0 0 000007ff 1 1 04 05 00 0
slli       0c 3 f 0000102c 00311093 1 2 0 0 00000003 1 1 01 02 00 0
srai       0d 0 f 00001030 40415093 1 7 0 0 00000004 1 1 01 02 00 0
lui        0e 1 f 00001034 123452b7 1 a 0 0 12345000 1 1 05 00 00 0
auipc      0f 2 f 00001038 fffff317 1 b 0 1 fffff000 1 1 06 00 00 0
jal_fwd    10 3 f 0000103c 008000ef 1 8 1 1 00000008 1 1 01 00 00 1
jal_back   11 0 f 00001040 ffdff06f 1 8 1 1 fffffffc 1 0 00 00 00 1
jalr       12 1 f 00001044 010100e7 1 9 1 0 00000010 1 1 01 02 00 1
beq        13 2 f 00001048 00208863 1 0 1 1 00000010 1 0 00 01 02 1
bne_back   14 3 f 0000104c fe209ce3 1 2 1 1 fffffff8 1 0 00 01 02 1
bgeu       15 0 f 00001050 0020f863 1 6 1 1 00000010 1 0 00 01 02 1
lw         16 1 f 00001054 00832283 2 2 0 0 00000008 1 1 05 06 00 0
lbu        17 2 f 00001058 fff44383 2 4 0 0 ffffffff 1 1 07 08 00 0
sw         18 3 f 0000105c 00532623 2 a 0 0 0000000c 1 0 00 06 05 0
sb         19 0 f 00001060 fe110f23 2 8 0 0 fffffffe 1 0 00 02 01 0
fence      1a 1 f 00001064 0ff0000f 2 f 0 0 00000000 0 0 00 00 00 0
ecall      1b 2 f 00001068 00000073 1 a 1 1 00000004 1 0 00 00 00 1
mret       1c 3 f 0000106c 30200073 1 e 1 1 00000004 1 0 00 00 00 1
csrrw      1d 0 f 00001070 300110f3 3 6 0 0 00000300 0 1 01 02 00 1
csrrci     1e 1 f 00001074 3412f273 3 8 0 0 00005341 1 1 04 00 00 1
csrrwi     1f 2 f 00001078 7c0fd073 3 6 0 0 0001f7c0 1 0 00 00 00 1
tmc        20 3 f 0000107c 0002800b 3 0 0 0 00000000 0 0 00 05 00 1
wspawn     21 0 1 00001080 0020900b 3 1 0 0 00000000 0 0 00 01 02 1
split      22 1 f 00001084 0002218b 3 2 0 0 00000000 0 1 03 04 00 1
pred       23 2 f 00001088 0083d00b 3 5 0 0 00000000 0 0 00 07 08 1
ext1_bad   24 3 f 0000108c 0000600b 0 0 0 0 00000000 0 0 00 00 00 0

// ==== decode_unit.f ====
+incdir+include
verilog/isa_pkg.sv
verilog/uop_pkg.sv
verilog/opcode_decoder.sv
verilog/func_decoder.sv
verilog/imm_gen.sv
verilog/decode_stage_reg.sv
verilog/decode_unit.sv
verif/tb_clock.sv
verif/decode_checker.sv
verif/decode_tb.sv

// ==== Bender.yml ====
package:
  name: decode_unit

sources:
  - include_dirs:
      - include
    files:
      - verilog/isa_pkg.sv
      - verilog/uop_pkg.sv
      - verilog/opcode_decoder.sv
      - verilog/func_decoder.sv
      - verilog/imm_gen.sv
      - verilog/decode_stage_reg.sv
      - verilog/decode_unit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_clock.sv
      - verif/decode_checker.sv
      - verif/decode_tb.sv
